/* hw/ctrl_params.svh */
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

`define CTRL_INSTR_W 32
`define CTRL_REG_W 5
`define CTRL_RA_REG 5'd31 // jal and jalr link through this register.

// ####################################################################
// instruction fields by their lowest bit
// ####################################################################

`define CTRL_OP_LSB 26
`define CTRL_RS_LSB 21
`define CTRL_RT_LSB 16
`define CTRL_RD_LSB 11
`define CTRL_SHAMT_LSB 6
`define CTRL_FUNCT_LSB 0

// ####################################################################
// opcodes
// ####################################################################

`define CTRL_OP_SPECIAL 6'b000000
`define CTRL_OP_REGIMM 6'b000001
`define CTRL_OP_J 6'b000010
`define CTRL_OP_JAL 6'b000011
`define CTRL_OP_BEQ 6'b000100
`define CTRL_OP_BNE 6'b000101
`define CTRL_OP_BLEZ 6'b000110
`define CTRL_OP_BGTZ 6'b000111
`define CTRL_OP_ADDI 6'b001000
`define CTRL_OP_ADDIU 6'b001001
`define CTRL_OP_SLTI 6'b001010
`define CTRL_OP_SLTIU 6'b001011
`define CTRL_OP_ANDI 6'b001100
`define CTRL_OP_ORI 6'b001101
`define CTRL_OP_XORI 6'b001110
`define CTRL_OP_LUI 6'b001111
`define CTRL_OP_LB 6'b100000
`define CTRL_OP_LH 6'b100001
`define CTRL_OP_LW 6'b100011
`define CTRL_OP_LBU 6'b100100
`define CTRL_OP_LHU 6'b100101
`define CTRL_OP_SB 6'b101000
`define CTRL_OP_SH 6'b101001
`define CTRL_OP_SW 6'b101011

// the rt field selects the branch under REGIMM.
`define CTRL_RT_BLTZ 5'b00000
`define CTRL_RT_BGEZ 5'b00001

// ####################################################################
// funct codes under SPECIAL
// ####################################################################

`define CTRL_FN_SLL 6'b000000
`define CTRL_FN_SRL 6'b000010
`define CTRL_FN_SRA 6'b000011
`define CTRL_FN_SLLV 6'b000100
`define CTRL_FN_SRLV 6'b000110
`define CTRL_FN_SRAV 6'b000111
`define CTRL_FN_JR 6'b001000
`define CTRL_FN_JALR 6'b001001
`define CTRL_FN_ADD 6'b100000
`define CTRL_FN_ADDU 6'b100001
`define CTRL_FN_SUB 6'b100010
`define CTRL_FN_SUBU 6'b100011
`define CTRL_FN_AND 6'b100100
`define CTRL_FN_OR 6'b100101
`define CTRL_FN_XOR 6'b100110
`define CTRL_FN_NOR 6'b100111
`define CTRL_FN_SLT 6'b101010
`define CTRL_FN_SLTU 6'b101011

`endif

/* hw/ctrl_pkg.sv */
`default_nettype none

`include "ctrl_params.svh"

package ctrl_pkg;

	typedef logic [`CTRL_INSTR_W-1:0] instr_t;
	typedef logic [`CTRL_REG_W-1:0] reg_addr_t; // register 0 stands for no register.
	typedef logic [1:0] timing_t;

	localparam timing_t t_never = 2'd3; // the operand is never used.

	// the order matters, since the decoder groups kinds by range.
	typedef enum logic [5:0] {
		kind_addu, kind_subu, kind_add, kind_sub, kind_sll, kind_srl,
		kind_sra, kind_and, kind_or, kind_nor, kind_xor, kind_slt,
		kind_sltu, kind_sllv, kind_srlv, kind_srav,
		kind_lui, kind_ori, kind_addi, kind_addiu, kind_andi, kind_xori,
		kind_slti, kind_sltiu,
		kind_lw, kind_lh, kind_lhu, kind_lb, kind_lbu,
		kind_sw, kind_sh, kind_sb,
		kind_beq, kind_bne, kind_blez, kind_bgez, kind_bltz, kind_bgtz,
		kind_j, kind_jal,
		kind_jr, kind_jalr,
		kind_unknown
	} instr_kind_t;

	typedef enum logic [2:0] {
		cls_none, cls_cal_r, cls_cal_i, cls_load, cls_store, cls_branch,
		cls_jump_i, cls_jump_r
	} dp_class_t;

	typedef enum logic [2:0] {
		fwd_orig, fwd_e_npc, fwd_m_npc, fwd_m_alu, fwd_w_rf
	} fwd_src_t;

	typedef enum logic [3:0] {
		npc_seq, npc_eq, npc_ne, npc_lez, npc_gez, npc_ltz, npc_gtz, npc_j, npc_reg
	} npc_mode_t;

	typedef enum logic [1:0] {
		ext_signed, ext_unsigned, ext_upper
	} ext_mode_t;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_nor, alu_xor, alu_slt,
		alu_sltu, alu_sll, alu_srl, alu_sra, alu_sllv, alu_srlv, alu_srav
	} alu_op_t;

	typedef enum logic [2:0] {
		dm_none, dm_w, dm_h, dm_hu, dm_b, dm_bu
	} dm_mode_t;

	typedef enum logic [1:0] {
		rd_none, rd_alu, rd_mem, rd_link
	} regdata_sel_t;

endpackage

`default_nettype wire

/* hw/instr_decoder.sv */
`default_nettype none

`include "ctrl_params.svh"

module instr_decoder (
	input wire ctrl_pkg::instr_t instr,
	output ctrl_pkg::instr_kind_t kind,
	output ctrl_pkg::dp_class_t dp_class,
	output ctrl_pkg::reg_addr_t reg1,
	output ctrl_pkg::reg_addr_t reg2,
	output ctrl_pkg::reg_addr_t regw,
	output ctrl_pkg::timing_t t_use1,
	output ctrl_pkg::timing_t t_use2
);

	logic [5:0] op;
	logic [5:0] funct;
	ctrl_pkg::reg_addr_t rs;
	ctrl_pkg::reg_addr_t rt;
	ctrl_pkg::reg_addr_t rd;
	logic rs_zero;
	logic rt_zero;
	logic rd_zero;
	logic shamt_zero;

	assign op = instr[`CTRL_OP_LSB +: 6];
	assign funct = instr[`CTRL_FUNCT_LSB +: 6];
	assign rs = instr[`CTRL_RS_LSB +: `CTRL_REG_W];
	assign rt = instr[`CTRL_RT_LSB +: `CTRL_REG_W];
	assign rd = instr[`CTRL_RD_LSB +: `CTRL_REG_W];
	assign rs_zero = (rs == '0);
	assign rt_zero = (rt == '0);
	assign rd_zero = (rd == '0);
	assign shamt_zero = (instr[`CTRL_SHAMT_LSB +: 5] == 5'd0);

	// ####################################################################
	// instruction kind
	// ####################################################################

	always_comb begin
		kind = ctrl_pkg::kind_unknown;
		case (op)
			`CTRL_OP_SPECIAL: begin
				case (funct)
					`CTRL_FN_ADDU: if (shamt_zero) kind = ctrl_pkg::kind_addu;
					`CTRL_FN_SUBU: if (shamt_zero) kind = ctrl_pkg::kind_subu;
					`CTRL_FN_ADD: if (shamt_zero) kind = ctrl_pkg::kind_add;
					`CTRL_FN_SUB: if (shamt_zero) kind = ctrl_pkg::kind_sub;
					`CTRL_FN_SLL: if (rs_zero) kind = ctrl_pkg::kind_sll; // the nop lands here.
					`CTRL_FN_SRL: if (rs_zero) kind = ctrl_pkg::kind_srl;
					`CTRL_FN_SRA: if (rs_zero) kind = ctrl_pkg::kind_sra;
					`CTRL_FN_AND: if (shamt_zero) kind = ctrl_pkg::kind_and;
					`CTRL_FN_OR: if (shamt_zero) kind = ctrl_pkg::kind_or;
					`CTRL_FN_NOR: if (shamt_zero) kind = ctrl_pkg::kind_nor;
					`CTRL_FN_XOR: if (shamt_zero) kind = ctrl_pkg::kind_xor;
					`CTRL_FN_SLT: if (shamt_zero) kind = ctrl_pkg::kind_slt;
					`CTRL_FN_SLTU: if (shamt_zero) kind = ctrl_pkg::kind_sltu;
					`CTRL_FN_SLLV: if (shamt_zero) kind = ctrl_pkg::kind_sllv;
					`CTRL_FN_SRLV: if (shamt_zero) kind = ctrl_pkg::kind_srlv;
					`CTRL_FN_SRAV: if (shamt_zero) kind = ctrl_pkg::kind_srav;
					`CTRL_FN_JR: if (rt_zero && rd_zero) kind = ctrl_pkg::kind_jr;
					`CTRL_FN_JALR: if (rt_zero) kind = ctrl_pkg::kind_jalr;
					default: ;
				endcase
			end
			`CTRL_OP_REGIMM: begin
				if (rt == `CTRL_RT_BGEZ)
					kind = ctrl_pkg::kind_bgez;
				else if (rt == `CTRL_RT_BLTZ)
					kind = ctrl_pkg::kind_bltz;
			end
			`CTRL_OP_LUI: if (rs_zero) kind = ctrl_pkg::kind_lui;
			`CTRL_OP_ORI: kind = ctrl_pkg::kind_ori;
			`CTRL_OP_ADDI: kind = ctrl_pkg::kind_addi;
			`CTRL_OP_ADDIU: kind = ctrl_pkg::kind_addiu;
			`CTRL_OP_ANDI: kind = ctrl_pkg::kind_andi;
			`CTRL_OP_XORI: kind = ctrl_pkg::kind_xori;
			`CTRL_OP_SLTI: kind = ctrl_pkg::kind_slti;
			`CTRL_OP_SLTIU: kind = ctrl_pkg::kind_sltiu;
			`CTRL_OP_LW: kind = ctrl_pkg::kind_lw;
			`CTRL_OP_LH: kind = ctrl_pkg::kind_lh;
			`CTRL_OP_LHU: kind = ctrl_pkg::kind_lhu;
			`CTRL_OP_LB: kind = ctrl_pkg::kind_lb;
			`CTRL_OP_LBU: kind = ctrl_pkg::kind_lbu;
			`CTRL_OP_SW: kind = ctrl_pkg::kind_sw;
			`CTRL_OP_SH: kind = ctrl_pkg::kind_sh;
			`CTRL_OP_SB: kind = ctrl_pkg::kind_sb;
			`CTRL_OP_BEQ: kind = ctrl_pkg::kind_beq;
			`CTRL_OP_BNE: kind = ctrl_pkg::kind_bne;
			`CTRL_OP_BLEZ: kind = ctrl_pkg::kind_blez;
			`CTRL_OP_BGTZ: if (rt_zero) kind = ctrl_pkg::kind_bgtz;
			`CTRL_OP_J: kind = ctrl_pkg::kind_j;
			`CTRL_OP_JAL: kind = ctrl_pkg::kind_jal;
			default: ;
		endcase
	end

	always_comb begin
		if (kind inside {[ctrl_pkg::kind_addu:ctrl_pkg::kind_srav]})
			dp_class = ctrl_pkg::cls_cal_r;
		else if (kind inside {[ctrl_pkg::kind_lui:ctrl_pkg::kind_sltiu]})
			dp_class = ctrl_pkg::cls_cal_i;
		else if (kind inside {[ctrl_pkg::kind_lw:ctrl_pkg::kind_lbu]})
			dp_class = ctrl_pkg::cls_load;
		else if (kind inside {[ctrl_pkg::kind_sw:ctrl_pkg::kind_sb]})
			dp_class = ctrl_pkg::cls_store;
		else if (kind inside {[ctrl_pkg::kind_beq:ctrl_pkg::kind_bgtz]})
			dp_class = ctrl_pkg::cls_branch;
		else if (kind inside {ctrl_pkg::kind_j, ctrl_pkg::kind_jal})
			dp_class = ctrl_pkg::cls_jump_i;
		else if (kind inside {ctrl_pkg::kind_jr, ctrl_pkg::kind_jalr})
			dp_class = ctrl_pkg::cls_jump_r;
		else
			dp_class = ctrl_pkg::cls_none;
	end

	// ####################################################################
	// register use and use times
	// ####################################################################

	always_comb begin
		reg1 = '0;
		reg2 = '0;
		regw = '0;
		t_use1 = ctrl_pkg::t_never;
		t_use2 = ctrl_pkg::t_never;
		case (dp_class)
			ctrl_pkg::cls_cal_r: begin
				reg1 = rs;
				reg2 = rt;
				regw = rd;
				t_use1 = 2'd1;
				t_use2 = 2'd1;
			end
			ctrl_pkg::cls_cal_i, ctrl_pkg::cls_load: begin
				reg1 = rs;
				regw = rt;
				t_use1 = 2'd1;
			end
			ctrl_pkg::cls_store: begin
				reg1 = rs;
				reg2 = rt;
				t_use1 = 2'd1;
				t_use2 = 2'd2; // store data is only needed in M.
			end
			ctrl_pkg::cls_branch: begin
				reg1 = rs;
				t_use1 = 2'd0; // branches compare in D.
				t_use2 = 2'd0;
				if (kind inside {ctrl_pkg::kind_beq, ctrl_pkg::kind_bne})
					reg2 = rt;
			end
			ctrl_pkg::cls_jump_i: begin
				if (kind == ctrl_pkg::kind_jal)
					regw = `CTRL_RA_REG;
			end
			ctrl_pkg::cls_jump_r: begin
				reg1 = rs;
				t_use1 = 2'd0;
				if (kind == ctrl_pkg::kind_jalr)
					regw = rd;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hw/stage_tracker.sv */
`default_nettype none

module stage_tracker (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic stall,
	input wire ctrl_pkg::instr_kind_t d_kind,
	input wire ctrl_pkg::dp_class_t d_class,
	input wire ctrl_pkg::reg_addr_t d_reg1,
	input wire ctrl_pkg::reg_addr_t d_reg2,
	input wire ctrl_pkg::reg_addr_t d_regw,
	output ctrl_pkg::instr_kind_t e_kind,
	output ctrl_pkg::dp_class_t e_class,
	output ctrl_pkg::reg_addr_t e_reg1,
	output ctrl_pkg::reg_addr_t e_reg2,
	output ctrl_pkg::reg_addr_t e_regw,
	output ctrl_pkg::instr_kind_t m_kind,
	output ctrl_pkg::dp_class_t m_class,
	output ctrl_pkg::reg_addr_t m_reg2,
	output ctrl_pkg::reg_addr_t m_regw,
	output ctrl_pkg::dp_class_t w_class,
	output ctrl_pkg::reg_addr_t w_regw,
	output ctrl_pkg::timing_t e_t_new,
	output ctrl_pkg::timing_t m_t_new
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			e_kind <= ctrl_pkg::kind_unknown;
			e_class <= ctrl_pkg::cls_none;
			e_reg1 <= '0;
			e_reg2 <= '0;
			e_regw <= '0;
			m_kind <= ctrl_pkg::kind_unknown;
			m_class <= ctrl_pkg::cls_none;
			m_reg2 <= '0;
			m_regw <= '0;
			w_class <= ctrl_pkg::cls_none;
			w_regw <= '0;
		end else begin
			if (stall) begin // a bubble enters E while D holds.
				e_kind <= ctrl_pkg::kind_unknown;
				e_class <= ctrl_pkg::cls_none;
				e_reg1 <= '0;
				e_reg2 <= '0;
				e_regw <= '0;
			end else begin
				e_kind <= d_kind;
				e_class <= d_class;
				e_reg1 <= d_reg1;
				e_reg2 <= d_reg2;
				e_regw <= d_regw;
			end
			m_kind <= e_kind;
			m_class <= e_class;
			m_reg2 <= e_reg2;
			m_regw <= e_regw;
			w_class <= m_class;
			w_regw <= m_regw;
		end
	end

	// cycles until the result of each stage can be forwarded.
	always_comb begin
		case (e_class)
			ctrl_pkg::cls_load: e_t_new = 2'd2;
			ctrl_pkg::cls_cal_r, ctrl_pkg::cls_cal_i: e_t_new = 2'd1;
			default: e_t_new = 2'd0;
		endcase
	end

	assign m_t_new = (m_class == ctrl_pkg::cls_load) ? 2'd1 : 2'd0;

endmodule

`default_nettype wire

/* hw/hazard_unit.sv */
`default_nettype none

module hazard_unit (
	input wire ctrl_pkg::reg_addr_t d_reg1,
	input wire ctrl_pkg::reg_addr_t d_reg2,
	input wire ctrl_pkg::timing_t d_t_use1,
	input wire ctrl_pkg::timing_t d_t_use2,
	input wire ctrl_pkg::reg_addr_t e_reg1,
	input wire ctrl_pkg::reg_addr_t e_reg2,
	input wire ctrl_pkg::reg_addr_t e_regw,
	input wire ctrl_pkg::dp_class_t e_class,
	input wire ctrl_pkg::timing_t e_t_new,
	input wire ctrl_pkg::reg_addr_t m_reg2,
	input wire ctrl_pkg::reg_addr_t m_regw,
	input wire ctrl_pkg::dp_class_t m_class,
	input wire ctrl_pkg::timing_t m_t_new,
	input wire ctrl_pkg::reg_addr_t w_regw,
	output logic stall,
	output logic pc_enable,
	output logic d_enable,
	output logic e_flush,
	output ctrl_pkg::fwd_src_t fwd_d1,
	output ctrl_pkg::fwd_src_t fwd_d2,
	output ctrl_pkg::fwd_src_t fwd_e1,
	output ctrl_pkg::fwd_src_t fwd_e2,
	output ctrl_pkg::fwd_src_t fwd_m
);

	logic e_jump;
	logic m_jump;
	logic m_alu;

	assign e_jump = e_class inside {ctrl_pkg::cls_jump_i, ctrl_pkg::cls_jump_r};
	assign m_jump = m_class inside {ctrl_pkg::cls_jump_i, ctrl_pkg::cls_jump_r};
	assign m_alu = m_class inside {ctrl_pkg::cls_cal_r, ctrl_pkg::cls_cal_i};

	function automatic logic hit(input ctrl_pkg::reg_addr_t src,
			input ctrl_pkg::reg_addr_t dst);
		return (src == dst) && (src != '0);
	endfunction

	// only D may take the link address straight from E.
	function automatic ctrl_pkg::fwd_src_t pick(input ctrl_pkg::reg_addr_t src,
			input logic from_e);
		if (from_e && e_jump && hit(src, e_regw))
			return ctrl_pkg::fwd_e_npc;
		if (m_jump && hit(src, m_regw))
			return ctrl_pkg::fwd_m_npc;
		if (m_alu && hit(src, m_regw))
			return ctrl_pkg::fwd_m_alu;
		if (hit(src, w_regw))
			return ctrl_pkg::fwd_w_rf;
		return ctrl_pkg::fwd_orig;
	endfunction

	// ####################################################################
	// stall when a value is needed before any stage can supply it
	// ####################################################################

	assign stall = (hit(d_reg1, e_regw) && (d_t_use1 < e_t_new))
		|| (hit(d_reg1, m_regw) && (d_t_use1 < m_t_new))
		|| (hit(d_reg2, e_regw) && (d_t_use2 < e_t_new))
		|| (hit(d_reg2, m_regw) && (d_t_use2 < m_t_new));

	assign pc_enable = ~stall;
	assign d_enable = ~stall;
	assign e_flush = stall;

	always_comb begin
		fwd_d1 = pick(d_reg1, 1'b1);
		fwd_d2 = pick(d_reg2, 1'b1);
		fwd_e1 = pick(e_reg1, 1'b0);
		fwd_e2 = pick(e_reg2, 1'b0);
		fwd_m = hit(m_reg2, w_regw) ? ctrl_pkg::fwd_w_rf : ctrl_pkg::fwd_orig;
	end

endmodule

`default_nettype wire

/* hw/stage_control.sv */
`default_nettype none

module stage_control (
	input wire ctrl_pkg::instr_kind_t d_kind,
	input wire ctrl_pkg::dp_class_t d_class,
	input wire ctrl_pkg::reg_addr_t d_reg1,
	input wire ctrl_pkg::reg_addr_t d_reg2,
	input wire ctrl_pkg::instr_kind_t e_kind,
	input wire ctrl_pkg::dp_class_t e_class,
	input wire ctrl_pkg::instr_kind_t m_kind,
	input wire ctrl_pkg::dp_class_t m_class,
	input wire ctrl_pkg::dp_class_t w_class,
	input wire ctrl_pkg::reg_addr_t w_regw,
	output ctrl_pkg::npc_mode_t npc_mode,
	output ctrl_pkg::ext_mode_t ext_mode,
	output ctrl_pkg::reg_addr_t rf_read_addr1,
	output ctrl_pkg::reg_addr_t rf_read_addr2,
	output logic alu_src,
	output ctrl_pkg::alu_op_t alu_op,
	output logic dm_write_enable,
	output ctrl_pkg::dm_mode_t dm_mode,
	output logic rf_write_enable,
	output ctrl_pkg::regdata_sel_t regdata_sel,
	output ctrl_pkg::reg_addr_t rf_write_addr
);

	// ####################################################################
	// D stage
	// ####################################################################

	always_comb begin
		case (d_class)
			ctrl_pkg::cls_branch: begin
				case (d_kind)
					ctrl_pkg::kind_beq: npc_mode = ctrl_pkg::npc_eq;
					ctrl_pkg::kind_bne: npc_mode = ctrl_pkg::npc_ne;
					ctrl_pkg::kind_blez: npc_mode = ctrl_pkg::npc_lez;
					ctrl_pkg::kind_bgez: npc_mode = ctrl_pkg::npc_gez;
					ctrl_pkg::kind_bltz: npc_mode = ctrl_pkg::npc_ltz;
					ctrl_pkg::kind_bgtz: npc_mode = ctrl_pkg::npc_gtz;
					default: npc_mode = ctrl_pkg::npc_seq;
				endcase
			end
			ctrl_pkg::cls_jump_i: npc_mode = ctrl_pkg::npc_j;
			ctrl_pkg::cls_jump_r: npc_mode = ctrl_pkg::npc_reg;
			default: npc_mode = ctrl_pkg::npc_seq;
		endcase
	end

	always_comb begin
		ext_mode = ctrl_pkg::ext_signed; // address offsets are signed too.
		if (d_class == ctrl_pkg::cls_cal_i) begin
			case (d_kind)
				ctrl_pkg::kind_lui: ext_mode = ctrl_pkg::ext_upper;
				ctrl_pkg::kind_ori, ctrl_pkg::kind_andi, ctrl_pkg::kind_xori:
					ext_mode = ctrl_pkg::ext_unsigned;
				default: ;
			endcase
		end
	end

	assign rf_read_addr1 = d_reg1;
	assign rf_read_addr2 = d_reg2;

	// ####################################################################
	// E stage
	// ####################################################################

	assign alu_src = e_class inside {ctrl_pkg::cls_cal_i, ctrl_pkg::cls_load, ctrl_pkg::cls_store};

	always_comb begin
		case (e_kind)
			ctrl_pkg::kind_addu, ctrl_pkg::kind_add, ctrl_pkg::kind_addi, ctrl_pkg::kind_addiu,
			ctrl_pkg::kind_lw, ctrl_pkg::kind_lh, ctrl_pkg::kind_lhu, ctrl_pkg::kind_lb,
			ctrl_pkg::kind_lbu, ctrl_pkg::kind_sw, ctrl_pkg::kind_sh, ctrl_pkg::kind_sb:
				alu_op = ctrl_pkg::alu_add;
			ctrl_pkg::kind_subu, ctrl_pkg::kind_sub: alu_op = ctrl_pkg::alu_sub;
			ctrl_pkg::kind_and, ctrl_pkg::kind_andi: alu_op = ctrl_pkg::alu_and;
			ctrl_pkg::kind_nor: alu_op = ctrl_pkg::alu_nor;
			ctrl_pkg::kind_xor, ctrl_pkg::kind_xori: alu_op = ctrl_pkg::alu_xor;
			ctrl_pkg::kind_slt, ctrl_pkg::kind_slti: alu_op = ctrl_pkg::alu_slt;
			ctrl_pkg::kind_sltu, ctrl_pkg::kind_sltiu: alu_op = ctrl_pkg::alu_sltu;
			ctrl_pkg::kind_sll: alu_op = ctrl_pkg::alu_sll;
			ctrl_pkg::kind_srl: alu_op = ctrl_pkg::alu_srl;
			ctrl_pkg::kind_sra: alu_op = ctrl_pkg::alu_sra;
			ctrl_pkg::kind_sllv: alu_op = ctrl_pkg::alu_sllv;
			ctrl_pkg::kind_srlv: alu_op = ctrl_pkg::alu_srlv;
			ctrl_pkg::kind_srav: alu_op = ctrl_pkg::alu_srav;
			default: alu_op = ctrl_pkg::alu_or; // or, ori and lui, whose immediate is pre-shifted.
		endcase
	end

	// ####################################################################
	// M and W stages
	// ####################################################################

	assign dm_write_enable = (m_class == ctrl_pkg::cls_store);

	always_comb begin
		case (m_kind)
			ctrl_pkg::kind_lw, ctrl_pkg::kind_sw: dm_mode = ctrl_pkg::dm_w;
			ctrl_pkg::kind_lh, ctrl_pkg::kind_sh: dm_mode = ctrl_pkg::dm_h;
			ctrl_pkg::kind_lhu: dm_mode = ctrl_pkg::dm_hu;
			ctrl_pkg::kind_lb, ctrl_pkg::kind_sb: dm_mode = ctrl_pkg::dm_b;
			ctrl_pkg::kind_lbu: dm_mode = ctrl_pkg::dm_bu;
			default: dm_mode = ctrl_pkg::dm_none;
		endcase
	end

	always_comb begin
		case (w_class)
			ctrl_pkg::cls_cal_r, ctrl_pkg::cls_cal_i: regdata_sel = ctrl_pkg::rd_alu;
			ctrl_pkg::cls_load: regdata_sel = ctrl_pkg::rd_mem;
			ctrl_pkg::cls_jump_i, ctrl_pkg::cls_jump_r: regdata_sel = ctrl_pkg::rd_link;
			default: regdata_sel = ctrl_pkg::rd_none;
		endcase
	end

	// register 0 is never written.
	assign rf_write_enable = (regdata_sel != ctrl_pkg::rd_none) && (w_regw != '0);
	assign rf_write_addr = w_regw;

endmodule

`default_nettype wire

/* hw/pipeline_control.sv */
`default_nettype none

module pipeline_control (
	input wire logic clk,
	input wire logic rst_n,
	input wire ctrl_pkg::instr_t d_instr,
	output logic pc_enable,
	output logic d_enable,
	output logic e_flush,
	output ctrl_pkg::npc_mode_t npc_mode,
	output ctrl_pkg::ext_mode_t ext_mode,
	output ctrl_pkg::reg_addr_t rf_read_addr1,
	output ctrl_pkg::reg_addr_t rf_read_addr2,
	output logic alu_src,
	output ctrl_pkg::alu_op_t alu_op,
	output logic dm_write_enable,
	output ctrl_pkg::dm_mode_t dm_mode,
	output logic rf_write_enable,
	output ctrl_pkg::regdata_sel_t regdata_sel,
	output ctrl_pkg::reg_addr_t rf_write_addr,
	output ctrl_pkg::fwd_src_t fwd_d1,
	output ctrl_pkg::fwd_src_t fwd_d2,
	output ctrl_pkg::fwd_src_t fwd_e1,
	output ctrl_pkg::fwd_src_t fwd_e2,
	output ctrl_pkg::fwd_src_t fwd_m
);

	ctrl_pkg::instr_kind_t d_kind, e_kind, m_kind;
	ctrl_pkg::dp_class_t d_class, e_class, m_class, w_class;
	ctrl_pkg::reg_addr_t d_reg1, d_reg2, d_regw;
	ctrl_pkg::reg_addr_t e_reg1, e_reg2, e_regw;
	ctrl_pkg::reg_addr_t m_reg2, m_regw, w_regw;
	ctrl_pkg::timing_t d_t_use1, d_t_use2, e_t_new, m_t_new;
	logic stall;

	instr_decoder u_decoder (
		.instr(d_instr),
		.kind(d_kind),
		.dp_class(d_class),
		.reg1(d_reg1),
		.reg2(d_reg2),
		.regw(d_regw),
		.t_use1(d_t_use1),
		.t_use2(d_t_use2)
	);

	// the remaining ports share their names with the wires above.
	stage_tracker u_tracker (.*);

	hazard_unit u_hazard (.*);

	stage_control u_control (.*);

endmodule

`default_nettype wire

/* verification/tb_pipeline_control.sv */
`default_nettype none

module tb_pipeline_control;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_VECTORS = 64;
	localparam int N_FIELDS = 20;
	localparam ctrl_pkg::instr_t RESET_INSTR = 32'h8C210000; // lw r1, 0(r1) stalls on itself.

	logic clk = 1'b0;
	logic rst_n;
	ctrl_pkg::instr_t d_instr;
	logic pc_enable;
	logic d_enable;
	logic e_flush;
	ctrl_pkg::npc_mode_t npc_mode;
	ctrl_pkg::ext_mode_t ext_mode;
	ctrl_pkg::reg_addr_t rf_read_addr1;
	ctrl_pkg::reg_addr_t rf_read_addr2;
	logic alu_src;
	ctrl_pkg::alu_op_t alu_op;
	logic dm_write_enable;
	ctrl_pkg::dm_mode_t dm_mode;
	logic rf_write_enable;
	ctrl_pkg::regdata_sel_t regdata_sel;
	ctrl_pkg::reg_addr_t rf_write_addr;
	ctrl_pkg::fwd_src_t fwd_d1;
	ctrl_pkg::fwd_src_t fwd_d2;
	ctrl_pkg::fwd_src_t fwd_e1;
	ctrl_pkg::fwd_src_t fwd_e2;
	ctrl_pkg::fwd_src_t fwd_m;

	logic [31:0] vec [0:MAX_VECTORS-1][0:N_FIELDS-1]; // column 0 is d_instr.
	int n_vec = 0;
	logic loaded = 1'b0;

	pipeline_control u_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ######################################################################
	// checks
	// ######################################################################

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "output check failed");
		end
	endtask

	task automatic check_reset_state();
		compare("pc_enable", 32'(pc_enable), 32'd1);
		compare("d_enable", 32'(d_enable), 32'd1);
		compare("e_flush", 32'(e_flush), 32'd0);
		compare("rf_write_enable", 32'(rf_write_enable), 32'd0);
		compare("dm_write_enable", 32'(dm_write_enable), 32'd0);
		compare("fwd_d1", 32'(fwd_d1), 32'd0);
		compare("fwd_d2", 32'(fwd_d2), 32'd0);
		compare("fwd_e1", 32'(fwd_e1), 32'd0);
		compare("fwd_e2", 32'(fwd_e2), 32'd0);
		compare("fwd_m", 32'(fwd_m), 32'd0);
	endtask

	task automatic check_vector(input int i);
		compare("pc_enable", 32'(pc_enable), vec[i][1]);
		compare("d_enable", 32'(d_enable), vec[i][2]);
		compare("e_flush", 32'(e_flush), vec[i][3]);
		compare("npc_mode", 32'(npc_mode), vec[i][4]);
		compare("ext_mode", 32'(ext_mode), vec[i][5]);
		compare("rf_read_addr1", 32'(rf_read_addr1), vec[i][6]);
		compare("rf_read_addr2", 32'(rf_read_addr2), vec[i][7]);
		compare("alu_src", 32'(alu_src), vec[i][8]);
		compare("alu_op", 32'(alu_op), vec[i][9]);
		compare("dm_write_enable", 32'(dm_write_enable), vec[i][10]);
		compare("dm_mode", 32'(dm_mode), vec[i][11]);
		compare("rf_write_enable", 32'(rf_write_enable), vec[i][12]);
		compare("regdata_sel", 32'(regdata_sel), vec[i][13]);
		compare("rf_write_addr", 32'(rf_write_addr), vec[i][14]);
		compare("fwd_d1", 32'(fwd_d1), vec[i][15]);
		compare("fwd_d2", 32'(fwd_d2), vec[i][16]);
		compare("fwd_e1", 32'(fwd_e1), vec[i][17]);
		compare("fwd_e2", 32'(fwd_e2), vec[i][18]);
		compare("fwd_m", 32'(fwd_m), vec[i][19]);
	endtask

	task automatic load_vectors();
		int fd;
		int cnt;
		string line;
		fd = $fopen("verification/control_vectors.txt", "r");
		if (fd == 0) begin
			$display("the vector file could not be opened");
			$display("ERRORS FOUND");
			$fatal(1, "no vectors");
		end
		while (!$feof(fd) && n_vec < MAX_VECTORS) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 8 || line.getc(0) == 8'h23)
				continue; // blank lines and comments.
			cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				vec[n_vec][0], vec[n_vec][1], vec[n_vec][2], vec[n_vec][3], vec[n_vec][4],
				vec[n_vec][5], vec[n_vec][6], vec[n_vec][7], vec[n_vec][8], vec[n_vec][9],
				vec[n_vec][10], vec[n_vec][11], vec[n_vec][12], vec[n_vec][13],
				vec[n_vec][14], vec[n_vec][15], vec[n_vec][16], vec[n_vec][17],
				vec[n_vec][18], vec[n_vec][19]);
			if (cnt != N_FIELDS) begin
				$display("vector line %0d does not hold %0d fields", n_vec, N_FIELDS);
				$display("ERRORS FOUND");
				$fatal(1, "bad vector file");
			end
			n_vec++;
		end
		$fclose(fd);
		if (n_vec == 0) begin
			$display("the vector file holds no vectors");
			$display("ERRORS FOUND");
			$fatal(1, "empty vector file");
		end
	endtask

	// ######################################################################
	// stimulus
	// ######################################################################

	initial begin
		rst_n = 1'b0;
		d_instr = RESET_INSTR;
		load_vectors();
		loaded = 1'b1;
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(posedge clk);
			#5;
			if (c < RESET_CYCLES - 1) begin
				#90 check_reset_state(); // the records are empty from the first edge on.
			end
		end
		rst_n = 1'b1;
		for (int i = 0; i < n_vec; i++) begin
			d_instr = vec[i][0];
			#90;
			check_vector(i);
			@(posedge clk);
			#5;
		end
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		wait (loaded);
		#((RESET_CYCLES + n_vec + 20) * CLK_PERIOD);
		$display("the run did not finish in time");
		$display("ERRORS FOUND");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

/* verification/control_vectors.txt */
# d_instr pc_en d_en e_flush npc ext rd_a1 rd_a2 alu_src alu_op dm_we dm_mode
# rf_we regdata_sel rf_wa fwd_d1 fwd_d2 fwd_e1 fwd_e2 fwd_m, all hex, one line per cycle.
00000821 1 1 0 0 0 00 00 0 3 0 0 0 0 00 0 0 0 0 0
00001023 1 1 0 0 0 00 00 0 0 0 0 0 0 00 0 0 0 0 0
00001824 1 1 0 0 0 00 00 0 1 0 0 0 0 00 0 0 0 0 0
00002004 1 1 0 0 0 00 00 0 2 0 0 1 1 01 0 0 0 0 0
00002803 1 1 0 0 0 00 00 0 b 0 0 1 1 02 0 0 0 0 0
3C060000 1 1 0 0 2 00 00 0 a 0 0 1 1 03 0 0 0 0 0
34070000 1 1 0 0 1 00 00 1 3 0 0 1 1 04 0 0 0 0 0
28080000 1 1 0 0 0 00 00 1 3 0 0 1 1 05 0 0 0 0 0
38090000 1 1 0 0 1 00 00 1 6 0 0 1 1 06 0 0 0 0 0
8C0A0000 1 1 0 0 0 00 00 1 5 0 0 1 1 07 0 0 0 0 0
940B0000 1 1 0 0 0 00 00 1 0 0 0 1 1 08 0 0 0 0 0
800C0000 1 1 0 0 0 00 00 1 0 0 1 1 1 09 0 0 0 0 0
AC000000 1 1 0 0 0 00 00 1 0 0 3 1 2 0a 0 0 0 0 0
A4000000 1 1 0 0 0 00 00 1 0 0 4 1 2 0b 0 0 0 0 0
10000000 1 1 0 1 0 00 00 1 0 1 1 1 2 0c 0 0 0 0 0
04010000 1 1 0 4 0 00 00 0 3 1 2 0 0 00 0 0 0 0 0
1C000000 1 1 0 6 0 00 00 0 3 0 0 0 0 00 0 0 0 0 0
08000000 1 1 0 7 0 00 00 0 3 0 0 0 0 00 0 0 0 0 0
FC000000 1 1 0 0 0 00 00 0 3 0 0 0 0 00 0 0 0 0 0
00000000 1 1 0 0 0 00 00 0 3 0 0 0 0 00 0 0 0 0 0
00000000 1 1 0 0 0 00 00 0 8 0 0 0 3 00 0 0 0 0 0
00000000 1 1 0 0 0 00 00 0 8 0 0 0 0 00 0 0 0 0 0
# alu forwarding and a write to register 0
00221821 1 1 0 0 0 01 02 0 8 0 0 0 1 00 0 0 0 0 0
00A62025 1 1 0 0 0 05 06 0 0 0 0 0 1 00 0 0 0 0 0
00643823 1 1 0 0 0 03 04 0 3 0 0 0 1 00 3 0 0 0 0
00220021 1 1 0 0 0 01 02 0 1 0 0 1 1 03 0 0 4 3 0
00000000 1 1 0 0 0 00 00 0 0 0 0 1 1 04 0 0 0 0 4
00000000 1 1 0 0 0 00 00 0 8 0 0 1 1 07 0 0 0 0 0
00000000 1 1 0 0 0 00 00 0 8 0 0 0 1 00 0 0 0 0 0
# load-use stalls, one cycle for an alu user and two for a branch
8C290000 1 1 0 0 0 01 00 0 8 0 0 0 1 00 0 0 0 0 0
01205021 0 0 1 0 0 09 00 1 0 0 0 0 1 00 0 0 0 0 0
01205021 1 1 0 0 0 09 00 0 3 0 1 0 1 00 0 0 0 0 0
8C2B0000 1 1 0 0 0 01 00 0 0 0 0 1 2 09 0 0 4 0 0
11600000 0 0 1 1 0 0b 00 1 0 0 0 0 0 00 0 0 0 0 0
11600000 0 0 1 1 0 0b 00 0 3 0 1 1 1 0a 0 0 0 0 0
11600000 1 1 0 1 0 0b 00 0 3 0 0 1 2 0b 4 0 0 0 0
# link forwarding, then a store after a load
0C000000 1 1 0 7 0 00 00 0 3 0 0 0 0 00 0 0 0 0 0
03E00008 1 1 0 8 0 1f 00 0 3 0 0 0 0 00 1 0 0 0 0
8C0C0000 1 1 0 0 0 00 00 0 3 0 0 0 0 00 0 0 2 0 0
AC0C0000 1 1 0 0 0 00 0c 1 0 0 0 1 3 1f 0 0 0 0 0
00000000 1 1 0 0 0 00 00 1 0 0 1 0 3 00 0 0 0 0 0
00000000 1 1 0 0 0 00 00 0 8 1 1 1 2 0c 0 0 0 0 4
00000000 1 1 0 0 0 00 00 0 8 0 0 0 0 00 0 0 0 0 0

/* verilog.f */
+incdir+hw
hw/ctrl_pkg.sv
hw/instr_decoder.sv
hw/stage_tracker.sv
hw/hazard_unit.sv
hw/stage_control.sv
hw/pipeline_control.sv
verification/tb_pipeline_control.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS ?= --binary --timing
TOP ?= tb_pipeline_control
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
